/* all.f */
+incdir+logic
logic/uart_dbg_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/dbg_mem.sv
logic/dbg_cmd_engine.sv
logic/uart_dbg_top.sv
verif/uart_dbg_props.sv
verif/uart_dbg_checker.sv
verif/uart_dbg_tb.sv

/* logic/dbg_cmd_engine.sv */
// Debug protocol FSM: parses host commands, moves bytes to and from memory
// and sends ACK, EOT and read data back over the transmitter.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module dbg_cmd_engine (
  input  logic                               clk,
  input  logic                               rst_i,
  input  uart_dbg_pkg::byte_t                rx_byte_i,
  input  logic                               rx_valid_i,
  output uart_dbg_pkg::byte_t                tx_data_o,
  output logic                               tx_start_o,
  input  logic                               tx_busy_i,
  output logic                               mem_we_o,
  output logic [`UART_DBG_MEM_ADDR_BITS-1:0] mem_addr_o,
  output uart_dbg_pkg::byte_t                mem_wdata_o,
  input  uart_dbg_pkg::byte_t                mem_rdata_i,
  output logic                               exec_o,
  output uart_dbg_pkg::doub_t                exec_addr_o
);
  import uart_dbg_pkg::*;

  localparam int ADDR_BITS = `UART_DBG_MEM_ADDR_BITS;
  localparam int LEN_BITS  = `UART_DBG_LEN_BITS;

  dbg_state_e           state_q;
  dbg_cmd_e             cmd_q;
  logic [2:0]           idx_q;
  doub_t                hdr_q;
  doub_t                hdr_next;
  logic [LEN_BITS-1:0]  len_q;
  logic [ADDR_BITS-1:0] maddr_q;
  logic                 rd_ready_q;
  doub_t                exec_addr_q;
  logic                 hdr_last;

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Header bytes arrive LSB first, so shift in from the top
  assign hdr_next = {rx_byte_i, hdr_q[63:8]};
  assign hdr_last = rx_valid_i && (idx_q == 3'd7);

  always_comb begin
    case (state_q)
      ST_RDATA: tx_data_o = mem_rdata_i;
      ST_EOT:   tx_data_o = CMD_EOT;
      default:  tx_data_o = CMD_ACK;
    endcase
  end

  // Only place a reply is held back while the transmitter is busy
  assign tx_start_o = !tx_busy_i &&
                      (state_q == ST_REPLY || state_q == ST_EOT ||
                       state_q == ST_EXEC  || (state_q == ST_RDATA && rd_ready_q));

  // Write byte goes straight into memory on its strobe
  assign mem_we_o    = (state_q == ST_WDATA) && rx_valid_i;
  assign mem_wdata_o = rx_byte_i;
  assign mem_addr_o  = maddr_q;

  assign exec_o      = (state_q == ST_EXEC);
  assign exec_addr_o = exec_addr_q;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      cmd_q      <= CMD_ACK;
      idx_q      <= '0;
      len_q      <= '0;
      maddr_q    <= '0;
      rd_ready_q <= 1'b0;
    end else begin
      // Registered read needs one quiet cycle after each address step
      rd_ready_q <= (state_q == ST_RDATA) && !tx_start_o;
      case (state_q)
        ST_IDLE: begin
          if (rx_valid_i) begin
            idx_q <= '0;
            case (rx_byte_i)
              CMD_ACK: begin
                cmd_q   <= CMD_ACK;
                state_q <= ST_REPLY;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= dbg_cmd_e'(rx_byte_i);
                state_q <= ST_ADDR;
              end
              // Anything else is dropped silently
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_valid_i) begin
            idx_q <= idx_q + 3'd1;
          end
          if (hdr_last) begin
            maddr_q <= hdr_next[ADDR_BITS-1:0];
            state_q <= (cmd_q == CMD_EXEC) ? ST_EXEC : ST_LEN;
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            idx_q <= idx_q + 3'd1;
          end
          if (hdr_last) begin
            len_q   <= hdr_next[LEN_BITS-1:0];
            state_q <= ST_REPLY;
          end
        end
        ST_REPLY: begin
          if (tx_start_o) begin
            case (cmd_q)
              CMD_READ:  state_q <= (len_q == '0) ? ST_EOT : ST_RDATA;
              CMD_WRITE: state_q <= (len_q == '0) ? ST_EOT : ST_WDATA;
              default:   state_q <= ST_IDLE;
            endcase
          end
        end
        // One-cycle pulse, ACK leaves now unless tx is still busy
        ST_EXEC: state_q <= tx_start_o ? ST_IDLE : ST_REPLY;
        ST_WDATA: begin
          if (rx_valid_i) begin
            maddr_q <= maddr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            if (len_q == LEN_BITS'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_RDATA: begin
          if (tx_start_o) begin
            maddr_q <= maddr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            if (len_q == LEN_BITS'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_EOT: begin
          if (tx_start_o) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Header shift and exec entry
  always_ff @(posedge clk) begin
    if (rx_valid_i && (state_q == ST_ADDR || state_q == ST_LEN)) begin
      hdr_q <= hdr_next;
    end
    if (state_q == ST_ADDR && hdr_last && cmd_q == CMD_EXEC) begin
      exec_addr_q <= hdr_next;
    end
  end

endmodule

/* logic/dbg_mem.sv */
// Byte-wide debug data memory, synchronous write and registered read.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module dbg_mem (
  input  logic                               clk,
  input  logic                               we_i,
  input  logic [`UART_DBG_MEM_ADDR_BITS-1:0] addr_i,
  input  uart_dbg_pkg::byte_t                wdata_i,
  output uart_dbg_pkg::byte_t                rdata_o
);
  import uart_dbg_pkg::*;

  localparam int DEPTH = 1 << `UART_DBG_MEM_ADDR_BITS;

  byte_t mem_q [DEPTH];

  // Read returns the old byte on a same-address write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

/* logic/uart_dbg_params.svh */
// Bit timing and memory sizing for the UART debug server.
// Included by the RTL and by the testbench.
`ifndef UART_DBG_PARAMS_SVH
`define UART_DBG_PARAMS_SVH

// Clock cycles per serial bit, a 10-bit frame lasts ten of these
`define UART_DBG_CLKS_PER_BIT 8

// Byte address width of the on-chip memory, addresses wrap above it
`define UART_DBG_MEM_ADDR_BITS 10

// Only this many low bits of the 64-bit length field are used
`define UART_DBG_LEN_BITS 16

`endif

/* logic/uart_dbg_pkg.sv */
// Types shared by the UART debug server RTL and its testbench.
// Modules take them by import.
package uart_dbg_pkg;

  // One serial byte
  typedef logic [7:0] byte_t;

  // Address or length as it travels on the wire, LSB first
  typedef logic [63:0] doub_t;

  // Protocol bytes, commands from the host and replies from the server
  typedef enum logic [7:0] {
    CMD_EOT   = 8'h04,
    CMD_ACK   = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_cmd_e;

  // Command engine FSM
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_ADDR  = 3'd1,
    ST_LEN   = 3'd2,
    ST_REPLY = 3'd3,
    ST_WDATA = 3'd4,
    ST_RDATA = 3'd5,
    ST_EOT   = 3'd6,
    ST_EXEC  = 3'd7
  } dbg_state_e;

endpackage

/* logic/uart_dbg_top.sv */
// UART debug server top, serial in and out plus the exec request.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_dbg_top (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                uart_rx_i,
  output logic                uart_tx_o,
  output logic                exec_o,
  output uart_dbg_pkg::doub_t exec_addr_o
);
  import uart_dbg_pkg::*;

  byte_t                              rx_byte;
  logic                               rx_valid;
  byte_t                              tx_data;
  logic                               tx_start;
  logic                               tx_busy;
  logic                               mem_we;
  logic [`UART_DBG_MEM_ADDR_BITS-1:0] mem_addr;
  byte_t                              mem_wdata;
  byte_t                              mem_rdata;

  uart_rx u_rx (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_i       (uart_rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  dbg_cmd_engine u_engine (
    .clk         (clk),
    .rst_i       (rst_i),
    .rx_byte_i   (rx_byte),
    .rx_valid_i  (rx_valid),
    .tx_data_o   (tx_data),
    .tx_start_o  (tx_start),
    .tx_busy_i   (tx_busy),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .exec_o      (exec_o),
    .exec_addr_o (exec_addr_o)
  );

  dbg_mem u_mem (
    .clk     (clk),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  uart_tx u_tx (
    .clk        (clk),
    .rst_i      (rst_i),
    .tx_data_i  (tx_data),
    .tx_start_i (tx_start),
    .tx_busy_o  (tx_busy),
    .tx_o       (uart_tx_o)
  );

endmodule

/* logic/uart_rx.sv */
// 8N1 serial receiver, one rx_valid_o pulse per good frame.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_rx (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                rx_i,
  output uart_dbg_pkg::byte_t rx_byte_o,
  output logic                rx_valid_o
);
  import uart_dbg_pkg::*;

  localparam int CPB   = `UART_DBG_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  logic [1:0]       sync_q;
  logic             active_q;
  logic [3:0]       bit_q;
  logic [CNT_W-1:0] cnt_q;
  byte_t            shift_q;
  logic             line;
  logic             centre;

  assign line      = sync_q[1];
  assign centre    = (cnt_q == CNT_W'(CPB - 1));
  assign rx_byte_o = shift_q;

  // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q     <= 2'b11;
      active_q   <= 1'b0;
      bit_q      <= '0;
      cnt_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      if (!active_q) begin
        // Half a bit head start puts the samples at bit centres
        if (!line) begin
          active_q <= 1'b1;
          bit_q    <= '0;
          cnt_q    <= CNT_W'(CPB / 2);
        end
      end else if (centre) begin
        cnt_q <= '0;
        bit_q <= bit_q + 4'd1;
        // Line back high at start centre is a glitch
        if (bit_q == 4'd0 && line) begin
          active_q <= 1'b0;
        end
        if (bit_q == 4'd9) begin
          active_q   <= 1'b0;
          rx_valid_o <= line;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active_q && centre && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

endmodule

/* logic/uart_tx.sv */
// 8N1 serial transmitter, sends one byte per tx_start_i in idle.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_tx (
  input  logic                clk,
  input  logic                rst_i,
  input  uart_dbg_pkg::byte_t tx_data_i,
  input  logic                tx_start_i,
  output logic                tx_busy_o,
  output logic                tx_o
);

  localparam int CPB   = `UART_DBG_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  logic             busy_q;
  logic [9:0]       frame_q;
  logic [3:0]       bit_q;
  logic [CNT_W-1:0] cnt_q;

  assign tx_busy_o = busy_q;
  // Idle line is high
  assign tx_o      = busy_q ? frame_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      bit_q  <= '0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q <= 1'b1;
        bit_q  <= '0;
        cnt_q  <= '0;
      end
    end else if (cnt_q == CNT_W'(CPB - 1)) begin
      cnt_q <= '0;
      bit_q <= bit_q + 4'd1;
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      frame_q <= {1'b1, tx_data_i, 1'b0};
    end else if (busy_q && cnt_q == CNT_W'(CPB - 1)) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the UART debug server testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module uart_dbg_tb -Mdir obj_dir -f all.f \
  && ./obj_dir/Vuart_dbg_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/uart_dbg_checker.sv */
// Decodes both serial lines of the debug server, models the protocol and
// compares every reply byte; prints one line per test and the totals.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_dbg_checker (
  input logic                clk,
  input logic                rst_i,
  input logic                host_line_i,
  input logic                dut_line_i,
  input logic                exec_i,
  input uart_dbg_pkg::doub_t exec_addr_i
);
  import uart_dbg_pkg::*;

  localparam int CPB      = `UART_DBG_CLKS_PER_BIT;
  localparam int MEM_SIZE = 1 << `UART_DBG_MEM_ADDR_BITS;

  byte_t    model_mem [MEM_SIZE];
  byte_t    exp_q [$];
  int       pending   = 0;
  int       err_cnt   = 0;
  int       pass_cnt  = 0;
  int       fail_cnt  = 0;
  int       test_base = 0;
  int       exec_exp  = 0;
  int       exec_seen = 0;
  doub_t    exec_entry;
  // Host command tracker, phase 0 idle, 1 address, 2 length, 3 write data
  int       phase     = 0;
  int       hdr_idx   = 0;
  int       remain    = 0;
  dbg_cmd_e cmd;
  doub_t    hdr;
  logic [`UART_DBG_MEM_ADDR_BITS-1:0] addr;

  function automatic logic line_level(input logic dut_side);
    return dut_side ? dut_line_i : host_line_i;
  endfunction

  // Start edge, then samples at bit centres
  task automatic read_frame(input logic dut_side, output byte_t b, output logic ok);
    do @(posedge clk); while (rst_i || line_level(dut_side));
    repeat (CPB / 2) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge clk);
      b[i] = line_level(dut_side);
    end
    repeat (CPB) @(posedge clk);
    ok = line_level(dut_side);
  endtask

  task automatic expect_byte(input byte_t b);
    exp_q.push_back(b);
    pending = exp_q.size();
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of the server
  ////////////////////////////////////////////////////////////

  task automatic host_byte(input byte_t b);
    case (phase)
      0: begin
        if (b == CMD_ACK) begin
          expect_byte(CMD_ACK);
        end else if (b == CMD_READ || b == CMD_WRITE || b == CMD_EXEC) begin
          cmd     = dbg_cmd_e'(b);
          hdr_idx = 0;
          phase   = 1;
        end
      end
      1, 2: begin
        // LSB first on the wire
        hdr = {b, hdr[63:8]};
        hdr_idx++;
        if (hdr_idx == 8 && phase == 1) begin
          hdr_idx = 0;
          addr    = hdr[`UART_DBG_MEM_ADDR_BITS-1:0];
          phase   = (cmd == CMD_EXEC) ? 0 : 2;
          if (cmd == CMD_EXEC) begin
            exec_entry = hdr;
            exec_exp++;
            expect_byte(CMD_ACK);
          end
        end else if (hdr_idx == 8) begin
          remain = int'(hdr[`UART_DBG_LEN_BITS-1:0]);
          expect_byte(CMD_ACK);
          phase = (cmd == CMD_WRITE && remain != 0) ? 3 : 0;
          if (cmd == CMD_READ) begin
            for (int i = 0; i < remain; i++) begin
              expect_byte(model_mem[addr]);
              addr++;
            end
          end
          if (phase == 0) begin
            expect_byte(CMD_EOT);
          end
        end
      end
      3: begin
        model_mem[addr] = b;
        addr++;
        remain--;
        if (remain == 0) begin
          expect_byte(CMD_EOT);
          phase = 0;
        end
      end
      default: phase = 0;
    endcase
  endtask

  initial begin : host_watch
    byte_t b;
    logic  ok;
    forever begin
      read_frame(1'b0, b, ok);
      if (ok) begin
        host_byte(b);
      end
    end
  end

  initial begin : dut_watch
    byte_t b;
    byte_t e;
    logic  ok;
    forever begin
      read_frame(1'b1, b, ok);
      if (!ok) begin
        $display("DUT frame with a low stop bit at %0.1f ns", $realtime);
        err_cnt++;
      end else if (exp_q.size() == 0) begin
        $display("Unexpected reply byte %02h from the DUT at %0.1f ns", b, $realtime);
        err_cnt++;
      end else begin
        e       = exp_q.pop_front();
        pending = exp_q.size();
        if (b !== e) begin
          $display("** Error at %0.1f ns: reply byte %02h, expected %02h", $realtime, b, e);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_i && exec_i) begin
      exec_seen++;
      if (exec_addr_i !== exec_entry) begin
        $display("** Error at %0.1f ns: exec_addr_o %016h, expected %016h",
                 $realtime, exec_addr_i, exec_entry);
        err_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic drop_pending(input int cycles);
    $display("No reply from the DUT within %0d cycles, %0d bytes missing",
             cycles, exp_q.size());
    err_cnt++;
    exp_q.delete();
    pending = 0;
  endtask

  task automatic finish_test(input string name);
    if (exec_seen != exec_exp) begin
      $display("Saw %0d exec pulses where %0d were due", exec_seen, exec_exp);
      err_cnt++;
    end
    exec_seen = 0;
    exec_exp  = 0;
    if (err_cnt == test_base) begin
      pass_cnt++;
      $display("[PASS] %s", name);
    end else begin
      fail_cnt++;
      $display("[FAIL] %s, %0d errors", name, err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  task automatic report(input int assert_fails);
    $display("Tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             pass_cnt, fail_cnt, err_cnt, assert_fails);
  endtask

endmodule

/* verif/uart_dbg_props.sv */
// Assertions on the debug server top, attached by bind.
// Each failure also counts into fails, which the testbench reads at the end.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_dbg_props (
  input logic                     clk,
  input logic                     rst_i,
  input logic                     tx_line_i,
  input logic                     exec_i,
  input uart_dbg_pkg::dbg_state_e state_i
);
  import uart_dbg_pkg::*;

  localparam int FRAME = 10 * `UART_DBG_CLKS_PER_BIT;

  int fails = 0;
  int idle_run_q;

  // Consecutive cycles spent in idle, saturating at one frame
  always_ff @(posedge clk) begin
    if (rst_i || state_i != ST_IDLE) begin
      idle_run_q <= 0;
    end else if (idle_run_q < FRAME) begin
      idle_run_q <= idle_run_q + 1;
    end
  end

  // Line sits at the idle level through reset
  a_reset_idle: assert property (@(posedge clk) rst_i |=> tx_line_i)
    else begin
      fails++;
      $error("uart_tx_o low while in reset");
    end

  // A whole frame into idle the last reply has left and the line is high
  a_engine_idle: assert property (@(posedge clk) disable iff (rst_i)
      (idle_run_q >= FRAME) |-> tx_line_i)
    else begin
      fails++;
      $error("uart_tx_o low while the engine is idle");
    end

  a_exec_single: assert property (@(posedge clk) disable iff (rst_i) exec_i |=> !exec_i)
    else begin
      fails++;
      $error("exec_o high for two cycles in a row");
    end

endmodule

bind uart_dbg_top uart_dbg_props props_i (
  .clk       (clk),
  .rst_i     (rst_i),
  .tx_line_i (uart_tx_o),
  .exec_i    (exec_o),
  .state_i   (u_engine.state_q)
);

/* verif/uart_dbg_tb.sv */
// Testbench top for the UART debug server: clock, reset, host serial driver
// and a seeded random command sequence. Checking lives in the checker.
`timescale 1ns/100ps
`include "uart_dbg_params.svh"

module uart_dbg_tb;
  import uart_dbg_pkg::*;

  localparam int CPB        = `UART_DBG_CLKS_PER_BIT;
  localparam int FRAME      = 10 * CPB;
  localparam int MAX_CYCLES = 20 * 52 * FRAME * 2;
  localparam int REPLY_WAIT = 60 * FRAME;

  logic  clk;
  logic  rst_i;
  logic  uart_rx_i;
  logic  uart_tx_o;
  logic  exec_o;
  doub_t exec_addr_o;
  int    cycles = 0;

  uart_dbg_top dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .uart_rx_i   (uart_rx_i),
    .uart_tx_o   (uart_tx_o),
    .exec_o      (exec_o),
    .exec_addr_o (exec_addr_o)
  );

  uart_dbg_checker chk_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .host_line_i (uart_rx_i),
    .dut_line_i  (uart_tx_o),
    .exec_i      (exec_o),
    .exec_addr_i (exec_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Host side of the serial link
  ////////////////////////////////////////////////////////////

  // Start, eight data bits LSB first, stop
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i <= frame[i];
      repeat (CPB) @(posedge clk);
    end
  endtask

  task automatic send_doub(input doub_t d);
    for (int i = 0; i < 8; i++) begin
      send_byte(d[8*i +: 8]);
    end
  endtask

  task automatic wait_replies();
    int n;
    n = 0;
    while (chk_i.pending != 0 && n < REPLY_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (chk_i.pending != 0) begin
      chk_i.drop_pending(REPLY_WAIT);
    end
  endtask

  // Length bits above 16 are random and must be ignored
  task automatic write_mem(input doub_t addr, input int len);
    send_byte(CMD_WRITE);
    send_doub(addr);
    send_doub({$urandom(), 16'($urandom()), 16'(len)});
    wait_replies();
    for (int i = 0; i < len; i++) begin
      send_byte(8'($urandom()));
    end
    wait_replies();
  endtask

  task automatic read_mem(input doub_t addr, input int len);
    send_byte(CMD_READ);
    send_doub(addr);
    send_doub({$urandom(), 16'($urandom()), 16'(len)});
    wait_replies();
  endtask

  initial begin
    doub_t base;
    int    len;
    int    off;
    byte_t junk;
    void'($urandom(32'h52e8_8a81));
    rst_i     = 1'b1;
    uart_rx_i = 1'b1;
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk);

    send_byte(CMD_ACK);
    wait_replies();
    chk_i.finish_test("ack challenge");

    for (int t = 0; t < 3; t++) begin
      base = {$urandom(), $urandom()};
      len  = $urandom_range(32, 1);
      // Last pass starts near the top and runs past it so the region wraps
      if (t == 2) begin
        base[9:0] = 10'(1008 + $urandom_range(15));
        len       = $urandom_range(32, 17);
      end
      write_mem(base, len);
      read_mem(base, len);
      chk_i.finish_test("write then read back");
    end

    // Two covering writes, then random overlaps inside the 48 bytes
    base = {$urandom(), $urandom()};
    write_mem(base, 32);
    write_mem(base + 64'd16, 32);
    for (int t = 0; t < 3; t++) begin
      off = $urandom_range(40);
      write_mem(base + 64'(off), $urandom_range(48 - off, 1));
    end
    read_mem(base, 48);
    off = $urandom_range(30);
    read_mem(base + 64'(off), $urandom_range(48 - off, 1));
    chk_i.finish_test("overlapping writes");

    write_mem({$urandom(), $urandom()}, 0);
    read_mem({$urandom(), $urandom()}, 0);
    chk_i.finish_test("zero length");

    for (int t = 0; t < 2; t++) begin
      send_byte(CMD_EXEC);
      send_doub({$urandom(), $urandom()});
      wait_replies();
      chk_i.finish_test("exec entry");
    end

    for (int t = 0; t < 2; t++) begin
      do begin
        junk = 8'($urandom());
      end while (junk == CMD_ACK || junk == CMD_READ || junk == CMD_WRITE ||
                 junk == CMD_EXEC);
      send_byte(junk);
      repeat (3 * FRAME) @(posedge clk);
      send_byte(CMD_ACK);
      wait_replies();
      chk_i.finish_test("unknown byte ignored");
    end

    chk_i.report(dut_i.props_i.fails);
    if (chk_i.err_cnt == 0 && chk_i.fail_cnt == 0 && dut_i.props_i.fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
